//--- verification/decode_issue_stim.txt
// pc instr id rs1_data rs2_data busy_mask busy_cycles not_ready_cycles flush unit exp_a exp_b exp_flags
// ALU: a=in1 b=in2 flags={subtract,slt_path}; branch: a=pc_offset flags={jal,jalr,use_signed,is_call,is_return}; ls: a=offset flags={load,store,forwarded_store}
00000100 123451B7 0 00000000 00000000 0 0 0 0 1 000000000 012345000 0
00000104 80000217 1 00000000 00000000 0 0 0 0 1 000000104 180000000 0
00000108 FFF30293 2 00000010 00000000 1 3 0 0 1 000000010 1FFFFFFFF 0
0000010C 002083B3 3 7FFFFFFF 00000001 2 2 0 0 1 07FFFFFFF 000000001 0
00000110 40208433 4 80000000 00000005 0 0 3 0 1 180000000 000000005 2
00000114 0020A4B3 5 FFFFFFFE 00000003 0 0 0 0 1 1FFFFFFFE 000000003 3
00000118 0020B533 6 FFFFFFFE 00000003 0 0 0 0 1 0FFFFFFFE 000000003 3
0000011C 00208863 7 00000005 00000005 3 2 0 0 2 000000010 000000000 04
00000120 FE20ECE3 0 00000001 00000002 0 0 0 0 2 0001FFFF8 000000000 00
00000124 001000EF 1 00000000 00000000 0 0 2 0 2 000000800 000000000 16
00000128 00008067 2 00000200 00000000 1 1 0 0 2 000000000 000000000 0D
0000012C FFDFF2EF 3 00000000 00000000 0 0 0 0 2 0001FFFFC 000000000 12
00000130 00100093 4 00000000 00000000 0 0 0 1 0 000000000 000000000 0
00000134 00812583 5 00001000 00000000 0 0 0 0 4 000000008 000000000 4
00000138 FE312E23 6 00001000 CAFE0000 2 1 0 0 4 000000FFC 000000000 3
0000013C 004102A3 7 00002000 000000AB 1 2 0 0 4 000000005 000000000 2
00000140 00208863 0 00000000 00000000 0 0 0 1 0 000000000 000000000 0
00000144 002083B3 1 00000012 00000034 0 0 1 0 1 000000012 000000034 0

//--- filelist.f
+incdir+common
common/decode_issue_pkg.sv
design/decode/instr_decoder.sv
design/issue/issue_stage.sv
design/issue/unit_dispatch.sv
design/decode_issue.sv
verification/decode_issue_checker.sv
verification/decode_issue_tb.sv

//--- verification/decode_issue_tb.sv
/*
 * Decode and issue testbench
 * File-driven instructions with operand stalls, unit back-pressure
 * and flushes, checked against expected unit input fields
 */
`default_nettype none

module decode_issue_tb;

    localparam int NUM_RECS = 18;
    localparam int FIELDS = 13;
    localparam int RESET_CYCLES = 16;
    localparam int CYCLE_LIMIT = 20 * NUM_RECS + RESET_CYCLES;

    // Column positions in a stimulus line
    localparam int F_PC = 0;
    localparam int F_INSTR = 1;
    localparam int F_ID = 2;
    localparam int F_RS1 = 3;
    localparam int F_RS2 = 4;
    localparam int F_MASK = 5;
    localparam int F_BUSY = 6;
    localparam int F_NOT_READY = 7;
    localparam int F_FLUSH = 8;
    localparam int F_UNIT = 9;
    localparam int F_A = 10;
    localparam int F_B = 11;
    localparam int F_FLAGS = 12;

    logic clk;
    logic rst;
    decode_issue_pkg::decode_packet_t decode;
    logic decode_advance;
    logic flush;
    decode_issue_pkg::reg_addr_t rs_addr [2];
    decode_issue_pkg::word_t rs_data [2];
    logic [1:0] rs_busy;
    decode_issue_pkg::unit_vec_t unit_ready;
    decode_issue_pkg::unit_vec_t issue_to;
    decode_issue_pkg::id_t issue_id;
    decode_issue_pkg::alu_inputs_t alu_inputs;
    decode_issue_pkg::branch_inputs_t branch_inputs;
    decode_issue_pkg::ls_inputs_t ls_inputs;

    logic [35:0] stim [0:NUM_RECS*FIELDS-1];
    int issue_queue [$];
    int cycle_count = 0;

    // Model of the issue stage occupant
    int next_rec;
    int cur_rec;
    logic occupied;
    int busy_left;
    int nr_left;
    logic flush_left;
    logic issued_now;
    logic flushed_now;
    logic accepted;

    decode_issue DUT (
        .clk            (clk),
        .rst            (rst),
        .decode         (decode),
        .decode_advance (decode_advance),
        .flush          (flush),
        .rs_addr        (rs_addr),
        .rs_data        (rs_data),
        .rs_busy        (rs_busy),
        .unit_ready     (unit_ready),
        .issue_to       (issue_to),
        .issue_id       (issue_id),
        .alu_inputs     (alu_inputs),
        .branch_inputs  (branch_inputs),
        .ls_inputs      (ls_inputs)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: instructions did not all issue within %0d cycles", CYCLE_LIMIT);
            $display("Testbench failed");
            $fatal(1, "Run stopped on timeout");
        end
    end

    function automatic logic [35:0] field(input int rec, input int idx);
        return stim[rec * FIELDS + idx];
    endfunction

    // Busy rs2 only holds back ALU and branch
    function automatic logic blocks_issue(input int rec);
        logic [1:0] mask;
        mask = 2'(field(rec, F_MASK));
        return mask[0] || (mask[1] && (3'(field(rec, F_UNIT)) != 3'b100));
    endfunction

    task automatic check_value(input string name, input logic [35:0] got,
                               input logic [35:0] expected);
        if (got !== expected) begin
            $display("FAIL %s got %h expected %h", name, got, expected);
            $display("Testbench failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic check_issue(input int rec);
        logic [2:0] unit;
        logic [31:0] instr;
        unit = 3'(field(rec, F_UNIT));
        instr = 32'(field(rec, F_INSTR));
        check_value("issue_id", issue_id, field(rec, F_ID));
        // Register numbers sit at fixed RV32I positions
        check_value("rs_addr[0]", rs_addr[0], instr[19:15]);
        if (unit != 3'b001 || instr[5]) begin
            check_value("rs_addr[1]", rs_addr[1], instr[24:20]);
        end
        case (unit)
            3'b001: begin
                check_value("alu_inputs.in1", alu_inputs.in1, field(rec, F_A));
                check_value("alu_inputs.in2", alu_inputs.in2, field(rec, F_B));
                check_value("alu_inputs.subtract/slt_path",
                    {alu_inputs.subtract, alu_inputs.slt_path}, field(rec, F_FLAGS));
            end
            3'b010: begin
                check_value("branch_inputs.pc", branch_inputs.pc, field(rec, F_PC));
                check_value("branch_inputs.pc_offset", {15'b0, branch_inputs.pc_offset},
                    field(rec, F_A));
                check_value("branch_inputs.flags",
                    {branch_inputs.jal, branch_inputs.jalr, branch_inputs.use_signed,
                     branch_inputs.is_call, branch_inputs.is_return}, field(rec, F_FLAGS));
            end
            default: begin
                check_value("ls_inputs.rs1", ls_inputs.rs1, field(rec, F_RS1));
                check_value("ls_inputs.rs2", ls_inputs.rs2, field(rec, F_RS2));
                check_value("ls_inputs.offset", ls_inputs.offset, field(rec, F_A));
                check_value("ls_inputs.flags",
                    {ls_inputs.load, ls_inputs.store, ls_inputs.forwarded_store},
                    field(rec, F_FLAGS));
            end
        endcase
    endtask

    ////////////////////////////////////////////////////
    // Observe at the falling edge, outputs are settled
    task automatic observe_cycle();
        logic stall;
        logic exp_advance;
        int rec;
        stall = occupied && (flush_left || (nr_left > 0)
                || ((busy_left > 0) && blocks_issue(cur_rec)));
        // Stage takes a new instruction when empty or issuing
        exp_advance = decode.valid && !stall;
        if (occupied && !stall) begin
            check_value("issue_to", issue_to, field(cur_rec, F_UNIT));
        end else begin
            check_value("issue_to", issue_to, 36'h0);
        end
        check_value("decode_advance", decode_advance, exp_advance);
        issued_now = 1'b0;
        if (issue_to != '0) begin
            rec = issue_queue.pop_front();
            check_issue(rec);
            issued_now = 1'b1;
        end
        flushed_now = occupied && flush;
        accepted = exp_advance;
    endtask

    task automatic update_state();
        if (issued_now || flushed_now) begin
            occupied = 1'b0;
            flush_left = 1'b0;
        end else if (occupied) begin
            if (busy_left > 0) busy_left--;
            if (nr_left > 0) nr_left--;
        end
        if (accepted) begin
            cur_rec = next_rec;
            occupied = 1'b1;
            busy_left = int'(field(next_rec, F_BUSY));
            nr_left = int'(field(next_rec, F_NOT_READY));
            flush_left = 1'(field(next_rec, F_FLUSH));
            if (!flush_left) begin
                issue_queue.push_back(next_rec);
            end
            next_rec++;
        end
    endtask

    task automatic drive_inputs();
        if (next_rec < NUM_RECS) begin
            decode.valid = 1'b1;
            decode.pc = 32'(field(next_rec, F_PC));
            decode.instruction = 32'(field(next_rec, F_INSTR));
            decode.id = 3'(field(next_rec, F_ID));
        end else begin
            decode = '0;
        end
        if (occupied) begin
            rs_data[0] = 32'(field(cur_rec, F_RS1));
            rs_data[1] = 32'(field(cur_rec, F_RS2));
            rs_busy = (busy_left > 0) ? 2'(field(cur_rec, F_MASK)) : 2'b00;
            unit_ready = (nr_left > 0) ? ~3'(field(cur_rec, F_UNIT)) : 3'b111;
            flush = flush_left;
        end else begin
            rs_data[0] = '0;
            rs_data[1] = '0;
            rs_busy = 2'b00;
            unit_ready = 3'b111;
            flush = 1'b0;
        end
    endtask

    initial begin
        $readmemh("verification/decode_issue_stim.txt", stim);
        rst = 1'b1;
        decode = '0;
        flush = 1'b0;
        rs_data[0] = '0;
        rs_data[1] = '0;
        rs_busy = 2'b00;
        unit_ready = 3'b111;
        next_rec = 0;
        cur_rec = 0;
        occupied = 1'b0;
        busy_left = 0;
        nr_left = 0;
        flush_left = 1'b0;
        // First edge clears the stage, then it stays idle
        @(posedge clk);
        repeat (RESET_CYCLES - 1) begin
            @(negedge clk);
            check_value("issue_to", issue_to, 36'h0);
            @(posedge clk);
        end
        #1;
        rst = 1'b0;
        drive_inputs();
        while ((next_rec < NUM_RECS) || occupied) begin
            @(negedge clk);
            observe_cycle();
            @(posedge clk);
            #1;
            update_state();
            drive_inputs();
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/decode_issue_checker.sv
/*
 * Decode and issue checker
 * Concurrent properties on the issue strobes of the top level
 */
`default_nettype none

module decode_issue_checker (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  decode_issue_pkg::unit_vec_t unit_ready,
    input  decode_issue_pkg::unit_vec_t issue_to
);

    // At most one unit per cycle
    issue_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(issue_to))
        else $error("issue_to has more than one bit set: %b", issue_to);

    // Never to a busy unit, never while flushing
    issue_allowed: assert property (@(posedge clk) disable iff (rst)
        ((issue_to & ~unit_ready) == '0) && !(flush && (issue_to != '0)))
        else $error("issue_to %b with unit_ready %b flush %b", issue_to, unit_ready, flush);

    issue_after_reset: assert property (@(posedge clk) rst |=> (issue_to == '0))
        else $error("issue_to %b in the cycle after reset", issue_to);

endmodule

bind decode_issue decode_issue_checker u_checker (
    .clk        (clk),
    .rst        (rst),
    .flush      (flush),
    .unit_ready (unit_ready),
    .issue_to   (issue_to)
);

`default_nettype wire

//--- design/decode_issue.sv
/*
 * Decode and issue stage, top level
 * Decoder, single-entry issue stage and unit dispatch
 */
`default_nettype none

module decode_issue (
    input  logic clk,
    input  logic rst,

    input  decode_issue_pkg::decode_packet_t decode,
    output logic decode_advance,
    input  logic flush,

    // Register file
    output decode_issue_pkg::reg_addr_t rs_addr [2],
    input  decode_issue_pkg::word_t rs_data [2],
    input  logic [1:0] rs_busy,

    // Units
    input  decode_issue_pkg::unit_vec_t unit_ready,
    output decode_issue_pkg::unit_vec_t issue_to,
    output decode_issue_pkg::id_t issue_id,
    output decode_issue_pkg::alu_inputs_t alu_inputs,
    output decode_issue_pkg::branch_inputs_t branch_inputs,
    output decode_issue_pkg::ls_inputs_t ls_inputs
);

    decode_issue_pkg::decoded_instr_t decoded;
    decode_issue_pkg::decoded_instr_t issued;

    instr_decoder u_decoder (
        .instruction (decode.instruction),
        .pc          (decode.pc),
        .id          (decode.id),
        .decoded     (decoded)
    );

    issue_stage u_issue (
        .clk            (clk),
        .rst            (rst),
        .decode         (decode),
        .decoded        (decoded),
        .flush          (flush),
        .unit_ready     (unit_ready),
        .rs_busy        (rs_busy),
        .decode_advance (decode_advance),
        .issued         (issued),
        .issue_to       (issue_to)
    );

    unit_dispatch u_dispatch (
        .issued        (issued),
        .rs_data       (rs_data),
        .rs_busy       (rs_busy),
        .alu_inputs    (alu_inputs),
        .branch_inputs (branch_inputs),
        .ls_inputs     (ls_inputs)
    );

    // Register reads follow the instruction in the issue stage
    assign rs_addr[0] = issued.rs1_addr;
    assign rs_addr[1] = issued.rs2_addr;
    assign issue_id = issued.id;

endmodule

`default_nettype wire

//--- design/issue/unit_dispatch.sv
/*
 * Unit dispatch
 * Forms the ALU, branch and load/store inputs from the
 * issued instruction and the register file data
 */
`default_nettype none

module unit_dispatch (
    input  decode_issue_pkg::decoded_instr_t issued,
    input  decode_issue_pkg::word_t rs_data [2],
    input  logic [1:0] rs_busy,
    output decode_issue_pkg::alu_inputs_t alu_inputs,
    output decode_issue_pkg::branch_inputs_t branch_inputs,
    output decode_issue_pkg::ls_inputs_t ls_inputs
);

    decode_issue_pkg::word_t alu_rs1_data;
    decode_issue_pkg::word_t alu_rs2_data;
    logic sign_ext;

    //////////////////////////////////////////////////
    // ALU
    assign alu_rs1_data = issued.rs1_use_regfile ? rs_data[0] : issued.pre_alu_rs1;
    assign alu_rs2_data = issued.rs2_use_regfile ? rs_data[1] : issued.pre_alu_rs2;

    // fn3[0] set means SLTU, compare as unsigned
    assign sign_ext = ~issued.fn3[0];

    always_comb begin
        alu_inputs.in1 = {alu_rs1_data[31] & sign_ext, alu_rs1_data};
        alu_inputs.in2 = {alu_rs2_data[31] & sign_ext, alu_rs2_data};
        alu_inputs.shifter_in = rs_data[0];
        // Register form takes the amount from rs2, immediate form from the rs2 field
        alu_inputs.shift_amount = issued.opcode[3] ? rs_data[1][4:0] : issued.rs2_addr;
        alu_inputs.logic_op = issued.alu_logic_op;
        alu_inputs.subtract = issued.alu_subtract;
        // Shift-in bit for SRA
        alu_inputs.arith = alu_rs1_data[31] & issued.instr30;
        alu_inputs.lshift = issued.alu_lshift;
        alu_inputs.shifter_path = issued.alu_shifter_path;
        alu_inputs.slt_path = issued.alu_slt_path;
    end

    //////////////////////////////////////////////////
    // Branch
    always_comb begin
        branch_inputs.rs1 = rs_data[0];
        branch_inputs.rs2 = rs_data[1];
        branch_inputs.pc = issued.pc;
        branch_inputs.pc_offset = issued.pc_offset;
        branch_inputs.fn3 = issued.fn3;
        branch_inputs.use_signed = issued.use_signed;
        // Opcode bit 3 only set for JAL, bit 2 for both jumps
        branch_inputs.jal = issued.opcode[1];
        branch_inputs.jalr = ~issued.opcode[1] & issued.opcode[0];
        branch_inputs.is_call = issued.is_call;
        branch_inputs.is_return = issued.is_return;
    end

    //////////////////////////////////////////////////
    // Load/store
    always_comb begin
        ls_inputs.rs1 = rs_data[0];
        ls_inputs.rs2 = rs_data[1];
        ls_inputs.offset = issued.ls_offset;
        ls_inputs.fn3 = issued.fn3;
        ls_inputs.load = issued.load;
        ls_inputs.store = issued.store;
        // Store data still in flight, picked up by the unit later
        ls_inputs.forwarded_store = rs_busy[1] & issued.uses_rs2 & ~rs_busy[0];
    end

endmodule

`default_nettype wire

//--- design/issue/issue_stage.sv
/*
 * Issue stage
 * Holds one decoded instruction and issues it to its unit
 * once the operands are free and the unit is ready
 */
`default_nettype none

`include "decode_issue_macros.svh"

module issue_stage (
    input  logic clk,
    input  logic rst,
    input  decode_issue_pkg::decode_packet_t decode,
    input  decode_issue_pkg::decoded_instr_t decoded,
    input  logic flush,
    input  decode_issue_pkg::unit_vec_t unit_ready,
    input  logic [1:0] rs_busy,
    output logic decode_advance,
    output decode_issue_pkg::decoded_instr_t issued,
    output decode_issue_pkg::unit_vec_t issue_to
);

    logic stage_valid;
    logic stage_ready;
    logic issue_valid;

    logic rs1_conflict;
    logic rs2_conflict;
    logic operands_free;
    decode_issue_pkg::unit_vec_t unit_operands_free;

    //////////////////////////////////////////////////
    // Stage register
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            stage_valid <= 1'b0;
        end else if (stage_ready) begin
            stage_valid <= decode.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (decode_advance) begin
            issued <= decoded;
        end
    end

    //////////////////////////////////////////////////
    // Operand hazards
    assign rs1_conflict = rs_busy[0] & issued.uses_rs1;
    assign rs2_conflict = rs_busy[1] & issued.uses_rs2;
    assign operands_free = ~rs1_conflict & ~rs2_conflict;

    // Load/store forwards a pending rs2 internally
    always_comb begin
        unit_operands_free = {`NUM_UNITS{operands_free}};
        unit_operands_free[`UNIT_LS] = ~rs1_conflict;
    end

    //////////////////////////////////////////////////
    // Issue and ready
    assign issue_valid = stage_valid & ~flush;

    // unit_needed is one-hot, so is issue_to
    assign issue_to = {`NUM_UNITS{issue_valid}} & unit_operands_free
                    & issued.unit_needed & unit_ready;

    // Empty, or emptying this cycle
    assign stage_ready = ~stage_valid | (|issue_to);
    assign decode_advance = decode.valid & stage_ready;

endmodule

`default_nettype wire

//--- design/decode/instr_decoder.sv
/*
 * Instruction decoder
 * Maps one RV32I instruction to its unit, source registers,
 * ALU pre-operands and control, branch offset and load/store fields
 */
`default_nettype none

`include "decode_issue_macros.svh"

module instr_decoder (
    input  decode_issue_pkg::word_t instruction,
    input  decode_issue_pkg::word_t pc,
    input  decode_issue_pkg::id_t id,
    output decode_issue_pkg::decoded_instr_t decoded
);

    logic [4:0] opcode_trim;
    logic [2:0] fn3;
    decode_issue_pkg::reg_addr_t rs1_addr;
    decode_issue_pkg::reg_addr_t rd_addr;

    logic is_lui;
    logic is_auipc;
    logic is_jal;
    logic is_jalr;
    logic sub_instr;
    logic rs1_link;
    logic rd_link;

    decode_issue_pkg::word_t pre_alu_rs2;
    decode_issue_pkg::alu_logic_op_t logic_op;

    logic [19:0] jal_imm;
    logic [11:0] jalr_imm;
    logic [11:0] br_imm;
    decode_issue_pkg::pc_offset_t pc_offset;

    assign opcode_trim = instruction[6:2];
    assign fn3 = instruction[14:12];
    assign rs1_addr = instruction[19:15];
    assign rd_addr = instruction[11:7];

    assign is_lui = (opcode_trim == `OPC_LUI);
    assign is_auipc = (opcode_trim == `OPC_AUIPC);
    assign is_jal = (opcode_trim == `OPC_JAL);
    assign is_jalr = (opcode_trim == `OPC_JALR);

    //////////////////////////////////////////////////
    // ALU pre-operands and control
    always_comb begin
        if (is_lui || is_auipc) begin
            pre_alu_rs2 = {instruction[31:12], 12'b0};
        end else if (is_jal || is_jalr) begin
            // Link address is pc + 4
            pre_alu_rs2 = 32'd4;
        end else begin
            pre_alu_rs2 = decode_issue_pkg::word_t'($signed(instruction[31:20]));
        end
    end

    // opcode_trim[3] is opcode bit 5, the register form of ARITH
    assign sub_instr = (fn3 == `FN3_ADD_SUB) && instruction[30] && opcode_trim[3];

    always_comb begin
        case (fn3)
            `FN3_XOR: logic_op = `ALU_OP_XOR;
            `FN3_OR:  logic_op = `ALU_OP_OR;
            `FN3_AND: logic_op = `ALU_OP_AND;
            default:  logic_op = `ALU_OP_ADD;
        endcase
        // LUI, AUIPC, JAL and JALR go through the adder
        if (opcode_trim[0]) begin
            logic_op = `ALU_OP_ADD;
        end
    end

    //////////////////////////////////////////////////
    // Branch and jump offsets
    assign jal_imm = {instruction[31], instruction[19:12], instruction[20], instruction[30:21]};
    assign jalr_imm = instruction[31:20];
    assign br_imm = {instruction[31], instruction[7], instruction[30:25], instruction[11:8]};

    always_comb begin
        if (is_jalr) begin
            pc_offset = decode_issue_pkg::pc_offset_t'($signed(jalr_imm));
        end else if (is_jal) begin
            pc_offset = decode_issue_pkg::pc_offset_t'($signed({jal_imm, 1'b0}));
        end else begin
            pc_offset = decode_issue_pkg::pc_offset_t'($signed({br_imm, 1'b0}));
        end
    end

    // x1 and x5 are link registers for return-address prediction
    assign rs1_link = (rs1_addr inside {5'd1, 5'd5});
    assign rd_link = (rd_addr inside {5'd1, 5'd5});

    //////////////////////////////////////////////////
    // Decoded record
    always_comb begin
        decoded.pc = pc;
        decoded.id = id;
        decoded.fn3 = fn3;
        decoded.instr30 = instruction[30];
        decoded.opcode = opcode_trim;
        decoded.rs1_addr = rs1_addr;
        decoded.rs2_addr = instruction[24:20];
        decoded.rd_addr = rd_addr;

        decoded.uses_rs1 = !(opcode_trim inside {`OPC_LUI, `OPC_AUIPC, `OPC_JAL});
        decoded.uses_rs2 = opcode_trim inside {`OPC_BRANCH, `OPC_STORE, `OPC_ARITH};

        decoded.unit_needed = '0;
        decoded.unit_needed[`UNIT_ALU] =
            opcode_trim inside {`OPC_ARITH, `OPC_ARITH_IMM, `OPC_AUIPC, `OPC_LUI};
        decoded.unit_needed[`UNIT_BRANCH] =
            opcode_trim inside {`OPC_BRANCH, `OPC_JAL, `OPC_JALR};
        decoded.unit_needed[`UNIT_LS] = opcode_trim inside {`OPC_LOAD, `OPC_STORE};

        decoded.pre_alu_rs1 = (is_auipc || is_jal || is_jalr) ? pc : '0;
        decoded.pre_alu_rs2 = pre_alu_rs2;
        decoded.rs1_use_regfile = !(is_lui || is_auipc || is_jal || is_jalr);
        decoded.rs2_use_regfile =
            !(is_lui || is_auipc || is_jal || is_jalr || (opcode_trim == `OPC_ARITH_IMM));

        decoded.alu_logic_op = logic_op;
        decoded.alu_subtract =
            ~opcode_trim[0] & ((fn3 inside {`FN3_SLT, `FN3_SLTU}) || sub_instr);
        decoded.alu_lshift = ~fn3[2];
        // Only SLL and SRL/SRA take the shifter
        decoded.alu_shifter_path = ~(opcode_trim[0] | (fn3 inside {`FN3_SLT, `FN3_SLTU,
            `FN3_XOR, `FN3_OR, `FN3_AND, `FN3_ADD_SUB}));
        decoded.alu_slt_path = ~opcode_trim[0] & (fn3 inside {`FN3_SLT, `FN3_SLTU});

        decoded.pc_offset = pc_offset;
        decoded.is_call = (is_jal || is_jalr) && rd_link;
        decoded.is_return = is_jalr && rs1_link && (!rd_link || (rs1_addr != rd_addr));
        decoded.use_signed = !(fn3 inside {`FN3_BLTU, `FN3_BGEU});

        // Stores split the offset around rd
        decoded.ls_offset = opcode_trim[3] ? {instruction[31:25], instruction[11:7]}
                                           : instruction[31:20];
        decoded.load = (opcode_trim == `OPC_LOAD);
        decoded.store = (opcode_trim == `OPC_STORE);
    end

endmodule

`default_nettype wire

//--- common/decode_issue_pkg.sv
/*
 * Shared types of the decode and issue stage
 * Vector typedefs and the packed records passed between blocks
 */
`default_nettype none

`include "decode_issue_macros.svh"

package decode_issue_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`ID_W-1:0] id_t;
    typedef logic [`NUM_UNITS-1:0] unit_vec_t;
    typedef logic [1:0] alu_logic_op_t;
    typedef logic signed [20:0] pc_offset_t;
    typedef logic [11:0] ls_offset_t;

    // From fetch
    typedef struct packed {
        logic valid;
        word_t pc;
        word_t instruction;
        id_t id;
    } decode_packet_t;

    //////////////////////////////////////////////////
    // Decoded instruction, held in the issue stage
    typedef struct packed {
        word_t pc;
        id_t id;
        logic [2:0] fn3;
        logic instr30;
        logic [4:0] opcode;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        reg_addr_t rd_addr;
        logic uses_rs1;
        logic uses_rs2;
        unit_vec_t unit_needed;
        // ALU operands used in place of register data
        word_t pre_alu_rs1;
        word_t pre_alu_rs2;
        logic rs1_use_regfile;
        logic rs2_use_regfile;
        alu_logic_op_t alu_logic_op;
        logic alu_subtract;
        logic alu_lshift;
        logic alu_shifter_path;
        logic alu_slt_path;
        // Branch unit
        pc_offset_t pc_offset;
        logic is_call;
        logic is_return;
        logic use_signed;
        // Load/store unit
        ls_offset_t ls_offset;
        logic load;
        logic store;
    } decoded_instr_t;

    //////////////////////////////////////////////////
    // Unit inputs
    typedef struct packed {
        logic [`XLEN:0] in1;
        logic [`XLEN:0] in2;
        word_t shifter_in;
        logic [`REG_ADDR_W-1:0] shift_amount;
        alu_logic_op_t logic_op;
        logic subtract;
        logic arith;
        logic lshift;
        logic shifter_path;
        logic slt_path;
    } alu_inputs_t;

    typedef struct packed {
        word_t rs1;
        word_t rs2;
        word_t pc;
        pc_offset_t pc_offset;
        logic [2:0] fn3;
        logic use_signed;
        logic jal;
        logic jalr;
        logic is_call;
        logic is_return;
    } branch_inputs_t;

    typedef struct packed {
        word_t rs1;
        word_t rs2;
        ls_offset_t offset;
        logic [2:0] fn3;
        logic load;
        logic store;
        logic forwarded_store;
    } ls_inputs_t;

endpackage

`default_nettype wire

//--- common/decode_issue_macros.svh
/*
 * Decode and issue stage constants
 * Widths, trimmed RV32I opcodes, function codes and unit bit positions
 */
`ifndef DECODE_ISSUE_MACROS_SVH
`define DECODE_ISSUE_MACROS_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define ID_W        3
`define NUM_UNITS   3

// Unit bit positions in issue_to and unit_ready
`define UNIT_ALU    0
`define UNIT_BRANCH 1
`define UNIT_LS     2

// Opcode bits [6:2]
`define OPC_LUI       5'b01101
`define OPC_AUIPC     5'b00101
`define OPC_JAL       5'b11011
`define OPC_JALR      5'b11001
`define OPC_BRANCH    5'b11000
`define OPC_LOAD      5'b00000
`define OPC_STORE     5'b01000
`define OPC_ARITH_IMM 5'b00100
`define OPC_ARITH     5'b01100

`define FN3_ADD_SUB 3'b000
`define FN3_SLT     3'b010
`define FN3_SLTU    3'b011
`define FN3_XOR     3'b100
`define FN3_OR      3'b110
`define FN3_AND     3'b111
`define FN3_BLTU    3'b110
`define FN3_BGEU    3'b111

`define ALU_OP_ADD 2'b00
`define ALU_OP_XOR 2'b01
`define ALU_OP_OR  2'b10
`define ALU_OP_AND 2'b11

`endif
